// ==== rtl/adc_loopback.sv ====
`include "pitaya_defines.svh"

module adc_loopback (
  input  logic                      adc_clk,
  input  logic                      reset_i,
  // deserialized converter words
  input  pitaya_pkg::adc_word_t     adc_dat_a_i,
  input  pitaya_pkg::adc_word_t     adc_dat_b_i,
  // DAC codes before the output registers
  input  pitaya_pkg::dac_code_t     mix_code_a_i,
  input  pitaya_pkg::dac_code_t     mix_code_b_i,
  input  logic                      digital_loop_i,   // 1 = feed DAC codes back
  // to acquisition
  output pitaya_pkg::scope_sample_t scope_a_o,
  output pitaya_pkg::scope_sample_t scope_b_o
);

  import pitaya_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // source select
  //////////////////////////////////////////////////////////////////////

  adc_word_t sel_a;   // full width before truncation
  adc_word_t sel_b;

  // ADC inputs arrive crossed but loopback codes do not
  assign sel_a = digital_loop_i ? mix_code_a_i : adc_dat_b_i;   // adc b -> ch a
  assign sel_b = digital_loop_i ? mix_code_b_i : adc_dat_a_i;   // adc a -> ch b

  //////////////////////////////////////////////////////////////////////
  // truncate and register
  //////////////////////////////////////////////////////////////////////

  // acquisition keeps the MSBs and drops 2 LSBs
  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      scope_a_o <= '0;
      scope_b_o <= '0;
    end else begin
      scope_a_o <= sel_a[`PITAYA_DAC_W-1 -: `PITAYA_SCOPE_W];
      scope_b_o <= sel_b[`PITAYA_DAC_W-1 -: `PITAYA_SCOPE_W];
    end
  end

endmodule

// ==== rtl/dac_mixer.sv ====
`include "pitaya_defines.svh"

module dac_mixer (
  input  logic                    adc_clk,
  input  logic                    reset_i,
  // generator samples
  input  pitaya_pkg::gen_sample_t asg_a_i,
  input  pitaya_pkg::gen_sample_t asg_b_i,
  // controller samples
  input  pitaya_pkg::gen_sample_t pid_a_i,
  input  pitaya_pkg::gen_sample_t pid_b_i,
  // unregistered codes for digital loopback
  output pitaya_pkg::dac_code_t   mix_code_a_o,
  output pitaya_pkg::dac_code_t   mix_code_b_o,
  // DAC pins
  output pitaya_pkg::dac_code_t   dac_dat_a_o,   // carries channel b
  output pitaya_pkg::dac_code_t   dac_dat_b_o,   // carries channel a
  output logic                    dac_reset_o
);

  import pitaya_pkg::*;

  // signed limits of the converter range
  localparam gen_sample_t SAT_POS = {1'b0, {(`PITAYA_DAC_W-1){1'b1}}};   // 8191
  localparam gen_sample_t SAT_NEG = {1'b1, {(`PITAYA_DAC_W-1){1'b0}}};   // -8192

  //////////////////////////////////////////////////////////////////////
  // sum, saturate, invert
  //////////////////////////////////////////////////////////////////////

  // one channel worth of mixing
  // overflow shows as the two top sum bits disagreeing
  function automatic dac_code_t mix_to_code(input gen_sample_t asg, input gen_sample_t pid);
    sum_t        sum;
    gen_sample_t clamped;
    sum = {{(`PITAYA_SUM_W-`PITAYA_DAC_W){asg[`PITAYA_DAC_W-1]}}, asg}
        + {{(`PITAYA_SUM_W-`PITAYA_DAC_W){pid[`PITAYA_DAC_W-1]}}, pid};
    if (sum[`PITAYA_SUM_W-1] != sum[`PITAYA_SUM_W-2]) begin
      clamped = sum[`PITAYA_SUM_W-1] ? SAT_NEG : SAT_POS;   // sign bit tells direction
    end else begin
      clamped = sum[`PITAYA_DAC_W-1:0];                     // in range so drop guard bit
    end
    // DAC wants the inverted code
    return ~clamped;
  endfunction

  assign mix_code_a_o = mix_to_code(asg_a_i, pid_a_i);
  assign mix_code_b_o = mix_to_code(asg_b_i, pid_b_i);

  //////////////////////////////////////////////////////////////////////
  // output pipeline
  //////////////////////////////////////////////////////////////////////

  dac_code_t code_a_q;   // stage 1 channel a
  dac_code_t code_b_q;   // stage 1 channel b

  // first stage keeps the channels in order
  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      code_a_q <= '0;
      code_b_q <= '0;
    end else begin
      code_a_q <= mix_code_a_o;
      code_b_q <= mix_code_b_o;
    end
  end

  // second stage sits next to the pins
  // board routes channel a to the b converter and back
  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      dac_dat_a_o <= '0;
      dac_dat_b_o <= '0;
    end else begin
      dac_dat_a_o <= code_b_q;   // ch b -> dac a
      dac_dat_b_o <= code_a_q;   // ch a -> dac b
    end
  end

  // converter reset follows system reset one cycle late
  always_ff @(posedge adc_clk) begin
    dac_reset_o <= reset_i;
  end

endmodule

// ==== rtl/pitaya_defines.svh ====
`ifndef PITAYA_DEFINES_SVH
`define PITAYA_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// sample and code widths
//////////////////////////////////////////////////////////////////////

`define PITAYA_DAC_W        14      // DAC code, generator and ADC sample
`define PITAYA_SUM_W        15      // generator + controller with one guard bit
`define PITAYA_SCOPE_W      12      // acquisition keeps the top bits only

//////////////////////////////////////////////////////////////////////
// daisy chain word and mode field
//////////////////////////////////////////////////////////////////////

`define PITAYA_DAISY_W      16      // parallel word to/from the daisy link
`define PITAYA_DAISY_MODE_W 3
`define PITAYA_SYNC_BIT     0       // sync mode shares the trigger over the chain
`define PITAYA_TRIG_SEL_BIT 2       // set selects generator trigger as output

// word sent while not in sync mode
`define PITAYA_DAISY_IDLE   16'h1234

`endif

// ==== rtl/pitaya_front_end.sv ====
`include "pitaya_defines.svh"

module pitaya_front_end (
  input  logic                      adc_clk,
  input  logic                      reset_i,
  // generator and controller samples
  input  pitaya_pkg::gen_sample_t   asg_a_i,
  input  pitaya_pkg::gen_sample_t   asg_b_i,
  input  pitaya_pkg::gen_sample_t   pid_a_i,
  input  pitaya_pkg::gen_sample_t   pid_b_i,
  // ADC
  input  pitaya_pkg::adc_word_t     adc_dat_a_i,
  input  pitaya_pkg::adc_word_t     adc_dat_b_i,
  input  logic                      digital_loop_i,
  // triggers and daisy chain
  input  logic                      trig_i,
  input  pitaya_pkg::daisy_word_t   par_dat_i,
  input  pitaya_pkg::daisy_mode_t   daisy_mode_i,
  input  logic                      asg_trig_i,
  input  logic                      scope_trig_i,
  input  logic                      daisy_rx_rdy_i,
  // DAC pins
  output pitaya_pkg::dac_code_t     dac_dat_a_o,
  output pitaya_pkg::dac_code_t     dac_dat_b_o,
  output logic                      dac_reset_o,
  // acquisition
  output pitaya_pkg::scope_sample_t scope_a_o,
  output pitaya_pkg::scope_sample_t scope_b_o,
  // trigger and daisy outputs
  output logic                      trig_ext_o,
  output logic                      trig_out_o,
  output pitaya_pkg::daisy_word_t   par_dat_o,
  output logic                      par_dv_o
);

  import pitaya_pkg::*;

  dac_code_t mix_code_a;   // unregistered codes from dac to loopback
  dac_code_t mix_code_b;

  //////////////////////////////////////////////////////////////////////
  // DAC path
  //////////////////////////////////////////////////////////////////////

  dac_mixer i_dac_mixer (
    .adc_clk      (adc_clk),
    .reset_i      (reset_i),
    .asg_a_i      (asg_a_i),
    .asg_b_i      (asg_b_i),
    .pid_a_i      (pid_a_i),
    .pid_b_i      (pid_b_i),
    .mix_code_a_o (mix_code_a),
    .mix_code_b_o (mix_code_b),
    .dac_dat_a_o  (dac_dat_a_o),
    .dac_dat_b_o  (dac_dat_b_o),
    .dac_reset_o  (dac_reset_o)
  );

  //////////////////////////////////////////////////////////////////////
  // ADC path
  //////////////////////////////////////////////////////////////////////

  adc_loopback i_adc_loopback (
    .adc_clk        (adc_clk),
    .reset_i        (reset_i),
    .adc_dat_a_i    (adc_dat_a_i),
    .adc_dat_b_i    (adc_dat_b_i),
    .mix_code_a_i   (mix_code_a),
    .mix_code_b_i   (mix_code_b),
    .digital_loop_i (digital_loop_i),
    .scope_a_o      (scope_a_o),
    .scope_b_o      (scope_b_o)
  );

  //////////////////////////////////////////////////////////////////////
  // triggers
  //////////////////////////////////////////////////////////////////////

  trigger_router i_trigger_router (
    .adc_clk        (adc_clk),
    .reset_i        (reset_i),
    .trig_i         (trig_i),
    .par_dat_i      (par_dat_i),
    .daisy_mode_i   (daisy_mode_i),
    .asg_trig_i     (asg_trig_i),
    .scope_trig_i   (scope_trig_i),
    .daisy_rx_rdy_i (daisy_rx_rdy_i),
    .trig_ext_o     (trig_ext_o),
    .trig_out_o     (trig_out_o),
    .par_dat_o      (par_dat_o),
    .par_dv_o       (par_dv_o)
  );

endmodule

// ==== rtl/pitaya_pkg.sv ====
`include "pitaya_defines.svh"

package pitaya_pkg;

  // two's complement generator and controller samples
  typedef logic signed [`PITAYA_DAC_W-1:0] gen_sample_t;

  // sum of two samples before saturation
  typedef logic signed [`PITAYA_SUM_W-1:0] sum_t;

  // inverted DAC code as seen on the pins
  typedef logic [`PITAYA_DAC_W-1:0] dac_code_t;

  // deserialized ADC word
  typedef logic [`PITAYA_DAC_W-1:0] adc_word_t;

  // sample handed to acquisition
  typedef logic [`PITAYA_SCOPE_W-1:0] scope_sample_t;

  //////////////////////////////////////////////////////////////////////
  // daisy chain
  //////////////////////////////////////////////////////////////////////

  typedef logic [`PITAYA_DAISY_W-1:0] daisy_word_t;       // tx/rx parallel word

  typedef logic [`PITAYA_DAISY_MODE_W-1:0] daisy_mode_t;  // sync / sel bits

endpackage

// ==== rtl/trigger_router.sv ====
`include "pitaya_defines.svh"

module trigger_router (
  input  logic                    adc_clk,
  input  logic                    reset_i,
  input  logic                    trig_i,           // external trigger pin
  input  pitaya_pkg::daisy_word_t par_dat_i,        // word from daisy rx
  input  pitaya_pkg::daisy_mode_t daisy_mode_i,
  input  logic                    asg_trig_i,       // generator trigger
  input  logic                    scope_trig_i,     // scope trigger
  input  logic                    daisy_rx_rdy_i,
  output logic                    trig_ext_o,
  output logic                    trig_out_o,
  output pitaya_pkg::daisy_word_t par_dat_o,        // word to daisy tx
  output logic                    par_dv_o
);

  import pitaya_pkg::*;

  localparam daisy_word_t IDLE_WORD = `PITAYA_DAISY_IDLE;

  logic sync_mode;
  logic daisy_trig_q;   // some bit of the rx word was set

  assign sync_mode = daisy_mode_i[`PITAYA_SYNC_BIT];

  //////////////////////////////////////////////////////////////////////
  // incoming daisy trigger
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      daisy_trig_q <= 1'b0;
    end else begin
      daisy_trig_q <= |par_dat_i;
    end
  end

  // chain trigger masks the local pin in sync mode
  assign trig_ext_o = trig_i & ~(sync_mode & daisy_trig_q);

  //////////////////////////////////////////////////////////////////////
  // outgoing trigger and tx word
  //////////////////////////////////////////////////////////////////////

  assign trig_out_o = daisy_mode_i[`PITAYA_TRIG_SEL_BIT] ? asg_trig_i : scope_trig_i;

  // sync mode puts the trigger on every bit
  assign par_dat_o = sync_mode ? {`PITAYA_DAISY_W{trig_out_o}} : IDLE_WORD;

  // no valid strobe while syncing
  assign par_dv_o = sync_mode ? 1'b0 : daisy_rx_rdy_i;

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the front end testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

if ! verilator --binary --timing --assert -f tb.f \
    --top-module tb_pitaya_front_end -o sim_tb; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb 2>&1)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "STATUS: PASS"; then
  exit 0
fi
exit 1

// ==== tb.f ====
+incdir+rtl
rtl/pitaya_pkg.sv
rtl/dac_mixer.sv
rtl/adc_loopback.sv
rtl/trigger_router.sv
rtl/pitaya_front_end.sv
tb/tb_pitaya_front_end.sv

// ==== tb/tb_pitaya_front_end.sv ====
`include "pitaya_defines.svh"

module tb_pitaya_front_end;

  import pitaya_pkg::*;

  localparam int CLK_PERIOD      = 40;
  localparam int RESET_CYCLES    = 5;
  localparam int RAND_CYCLES     = 800;   // per loop setting
  localparam int MIXED_CYCLES    = 300;   // loop bit random per cycle
  localparam int DIRECTED_CYCLES = 40;    // saturation cases, mid-run reset, drain
  localparam int PLAN_CYCLES     = RESET_CYCLES + 2 * RAND_CYCLES + MIXED_CYCLES
                                   + DIRECTED_CYCLES;
  localparam int TIMEOUT_CYCLES  = PLAN_CYCLES * 3 / 2;

  localparam gen_sample_t POS_LIMIT = 14'h1fff;   // +8191
  localparam gen_sample_t NEG_LIMIT = 14'h2000;   // -8192

  logic adc_clk = 1'b0;
  logic reset_i;
  gen_sample_t asg_a_i, asg_b_i, pid_a_i, pid_b_i;
  adc_word_t adc_dat_a_i, adc_dat_b_i;
  logic digital_loop_i;
  logic trig_i, asg_trig_i, scope_trig_i, daisy_rx_rdy_i;
  daisy_word_t par_dat_i;
  daisy_mode_t daisy_mode_i;
  dac_code_t dac_dat_a_o, dac_dat_b_o;
  logic dac_reset_o;
  scope_sample_t scope_a_o, scope_b_o;
  logic trig_ext_o, trig_out_o, par_dv_o;
  daisy_word_t par_dat_o;

  logic [31:0] rng_state = 32'haaf776b4;
  int cycle_count = 0;
  int err_dac = 0;
  int err_rst = 0;
  int err_scope = 0;
  int err_trig = 0;
  int err_directed = 0;

  pitaya_front_end UUT (.*);

  always #(CLK_PERIOD / 2) adc_clk = ~adc_clk;

  //////////////////////////////////////////////////////////////////////
  // reference model helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // clamp the true sum to the converter range and take the complement
  function automatic dac_code_t expected_code(input gen_sample_t asg, input gen_sample_t pid);
    int total;
    logic [`PITAYA_DAC_W-1:0] clamped;
    total = int'(asg) + int'(pid);
    if (total > 8191) begin
      total = 8191;
    end else if (total < -8192) begin
      total = -8192;
    end
    clamped = total[`PITAYA_DAC_W-1:0];
    return ~clamped;
  endfunction

  function automatic scope_sample_t top_bits(input logic [`PITAYA_DAC_W-1:0] w);
    return w[`PITAYA_DAC_W-1 -: `PITAYA_SCOPE_W];   // acquisition drops 2 LSBs
  endfunction

  // limits and zero show up often among the random values
  function automatic gen_sample_t pick_sample(input logic [31:0] r);
    case (r[16:14])
      3'd0:    return POS_LIMIT;
      3'd1:    return NEG_LIMIT;
      3'd2:    return '0;
      default: return r[13:0];
    endcase
  endfunction

  task automatic draw_rand(output logic [31:0] r);
    rng_state = xorshift32(rng_state);
    r = rng_state;
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
    $display("Mismatch %s: got %0h expected %0h at cycle %0d", name, got, want, cycle_count);
  endtask

  //////////////////////////////////////////////////////////////////////
  // checker on the falling edge
  //////////////////////////////////////////////////////////////////////

  logic rst_d1 = 1'b1;   // reset seen before the last posedge
  logic rst_d2 = 1'b1;
  dac_code_t code_a_d1 = '0, code_a_d2 = '0;   // model codes one and two cycles back
  dac_code_t code_b_d1 = '0, code_b_d2 = '0;
  adc_word_t adc_a_d1 = '0, adc_b_d1 = '0;
  logic loop_d1 = 1'b0;
  logic par_any_d1 = 1'b0;   // some rx bit was set
  dac_code_t now_code_a, now_code_b, exp_dac_a, exp_dac_b;
  scope_sample_t exp_scope_a, exp_scope_b;
  logic exp_trig_q, sync_mode, exp_trig_ext, exp_trig_out, exp_par_dv;
  daisy_word_t exp_par_dat;

  always @(negedge adc_clk) begin
    now_code_a = expected_code(asg_a_i, pid_a_i);
    now_code_b = expected_code(asg_b_i, pid_b_i);
    // two stages and channel a lands on dac b
    exp_dac_a = (rst_d1 || rst_d2) ? '0 : code_b_d2;
    exp_dac_b = (rst_d1 || rst_d2) ? '0 : code_a_d2;
    assert (dac_dat_a_o === exp_dac_a) else begin
      report_mismatch("dac_dat_a_o", 32'(dac_dat_a_o), 32'(exp_dac_a));
      err_dac++;
    end
    assert (dac_dat_b_o === exp_dac_b) else begin
      report_mismatch("dac_dat_b_o", 32'(dac_dat_b_o), 32'(exp_dac_b));
      err_dac++;
    end
    assert (dac_reset_o === rst_d1) else begin
      report_mismatch("dac_reset_o", 32'(dac_reset_o), 32'(rst_d1));
      err_rst++;
    end
    // adc inputs crossed while loopback codes go straight
    exp_scope_a = rst_d1 ? '0 : (loop_d1 ? top_bits(code_a_d1) : top_bits(adc_b_d1));
    exp_scope_b = rst_d1 ? '0 : (loop_d1 ? top_bits(code_b_d1) : top_bits(adc_a_d1));
    assert (scope_a_o === exp_scope_a) else begin
      report_mismatch("scope_a_o", 32'(scope_a_o), 32'(exp_scope_a));
      err_scope++;
    end
    assert (scope_b_o === exp_scope_b) else begin
      report_mismatch("scope_b_o", 32'(scope_b_o), 32'(exp_scope_b));
      err_scope++;
    end

    // trigger routing
    exp_trig_q   = !rst_d1 && par_any_d1;
    sync_mode    = daisy_mode_i[`PITAYA_SYNC_BIT];
    exp_trig_ext = trig_i && !(sync_mode && exp_trig_q);
    exp_trig_out = daisy_mode_i[`PITAYA_TRIG_SEL_BIT] ? asg_trig_i : scope_trig_i;
    exp_par_dat  = sync_mode ? {`PITAYA_DAISY_W{exp_trig_out}} : `PITAYA_DAISY_IDLE;
    exp_par_dv   = sync_mode ? 1'b0 : daisy_rx_rdy_i;
    assert (trig_ext_o === exp_trig_ext) else begin
      report_mismatch("trig_ext_o", 32'(trig_ext_o), 32'(exp_trig_ext));
      err_trig++;
    end
    assert (trig_out_o === exp_trig_out) else begin
      report_mismatch("trig_out_o", 32'(trig_out_o), 32'(exp_trig_out));
      err_trig++;
    end
    assert (par_dat_o === exp_par_dat) else begin
      report_mismatch("par_dat_o", 32'(par_dat_o), 32'(exp_par_dat));
      err_trig++;
    end
    assert (par_dv_o === exp_par_dv) else begin
      report_mismatch("par_dv_o", 32'(par_dv_o), 32'(exp_par_dv));
      err_trig++;
    end

    // shift history
    rst_d2     = rst_d1;
    rst_d1     = reset_i;
    code_a_d2  = code_a_d1;
    code_b_d2  = code_b_d1;
    code_a_d1  = now_code_a;
    code_b_d1  = now_code_b;
    adc_a_d1   = adc_dat_a_i;
    adc_b_d1   = adc_dat_b_i;
    loop_d1    = digital_loop_i;
    par_any_d1 = |par_dat_i;
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  // loop_mode 0 off, 1 on, 2 random per cycle
  task automatic drive_random(input int n_cycles, input logic [1:0] loop_mode);
    logic [31:0] r0, r1, r2, r3;
    for (int i = 0; i < n_cycles; i++) begin
      @(posedge adc_clk);
      draw_rand(r0);
      draw_rand(r1);
      draw_rand(r2);
      draw_rand(r3);
      asg_a_i        <= pick_sample(r0);
      asg_b_i        <= pick_sample(r1);
      pid_a_i        <= pick_sample(r2);
      pid_b_i        <= pick_sample(r3);
      adc_dat_a_i    <= r0[31:18];
      adc_dat_b_i    <= r1[31:18];
      digital_loop_i <= (loop_mode == 2'd2) ? r3[24] : loop_mode[0];
      trig_i         <= r3[31];
      asg_trig_i     <= r3[30];
      scope_trig_i   <= r3[29];
      daisy_rx_rdy_i <= r3[28];
      daisy_mode_i   <= r3[27:25];
      par_dat_i      <= r3[23] ? r2[31:16] : '0;   // zero half the time
    end
  endtask

  // hold one input set until it reaches the pins and compare with known codes
  task automatic check_saturation(input gen_sample_t a_asg, input gen_sample_t a_pid,
                                  input gen_sample_t b_asg, input gen_sample_t b_pid,
                                  input dac_code_t want_a, input dac_code_t want_b);
    @(posedge adc_clk);
    asg_a_i <= a_asg;
    pid_a_i <= a_pid;
    asg_b_i <= b_asg;
    pid_b_i <= b_pid;
    repeat (2) @(posedge adc_clk);
    @(negedge adc_clk);
    assert (dac_dat_b_o === want_a) else begin   // channel a on dac b
      report_mismatch("dac_dat_b_o", 32'(dac_dat_b_o), 32'(want_a));
      err_directed++;
    end
    assert (dac_dat_a_o === want_b) else begin
      report_mismatch("dac_dat_a_o", 32'(dac_dat_a_o), 32'(want_b));
      err_directed++;
    end
  endtask

  task automatic pulse_reset(input int n_cycles);
    @(posedge adc_clk);
    reset_i <= 1'b1;
    repeat (n_cycles) @(posedge adc_clk);
    reset_i <= 1'b0;
  endtask

  initial begin
    int total;
    reset_i        = 1'b1;
    asg_a_i        = '0;
    asg_b_i        = '0;
    pid_a_i        = '0;
    pid_b_i        = '0;
    adc_dat_a_i    = '0;
    adc_dat_b_i    = '0;
    digital_loop_i = 1'b0;
    trig_i         = 1'b0;
    asg_trig_i     = 1'b0;
    scope_trig_i   = 1'b0;
    daisy_rx_rdy_i = 1'b0;
    par_dat_i      = '0;
    daisy_mode_i   = '0;
    repeat (RESET_CYCLES) @(posedge adc_clk);
    reset_i <= 1'b0;

    drive_random(RAND_CYCLES, 2'd0);
    // overflow both ways, exact limits, small values
    check_saturation(POS_LIMIT, 14'h0001, NEG_LIMIT, 14'h3fff, 14'h2000, 14'h1fff);
    check_saturation(POS_LIMIT, POS_LIMIT, NEG_LIMIT, NEG_LIMIT, 14'h2000, 14'h1fff);
    check_saturation(14'h0fa0, 14'h105f, 14'h3060, 14'h2fa0, 14'h2000, 14'h1fff);
    check_saturation(14'h0000, 14'h0000, 14'h3fff, 14'h0000, 14'h3fff, 14'h0000);
    drive_random(RAND_CYCLES, 2'd1);
    pulse_reset(3);   // dac_reset_o must follow again
    drive_random(MIXED_CYCLES, 2'd2);
    repeat (4) @(posedge adc_clk);

    total = err_dac + err_rst + err_scope + err_trig + err_directed;
    $display("errors: dac %0d, dac_reset %0d, scope %0d, trigger %0d, directed %0d",
             err_dac, err_rst, err_scope, err_trig, err_directed);
    if (total == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // hang guard
  always @(posedge adc_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: stimulus did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("STATUS: FAIL");
      $finish;
    end
  end

endmodule
